// ==== logic/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// ------------------------------
// Block geometry
// ------------------------------

// Words held by the one cache block
`define CACHE_BLOCK_WORDS 16

// Bits needed to pick a word inside the block
`define CACHE_INDEX_BITS 4

// Lowest address bit of the block tag
// Byte offset is 2 bits, word index sits just above it
`define CACHE_TAG_LSB 6

// ------------------------------
// Bus width
// ------------------------------

// CPU and memory data path
`define CACHE_WORD_BITS 32

`endif

// ==== logic/cache_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

    // Widths that carry a meaning
    typedef logic [`CACHE_WORD_BITS-1:0]                 word_t;
    typedef logic [`CACHE_WORD_BITS-`CACHE_TAG_LSB-1:0]  block_tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0]                word_index_t;
    typedef logic [`CACHE_WORD_BITS/8-1:0]               byte_en_t;

    // Hart request, read and write are exclusive
    typedef struct packed {
        logic     read;
        logic     write;
        word_t    addr;
        word_t    wdata;
        byte_en_t be;
    } cpu_req_t;

    // Burst request, addr is the block base for the whole burst
    typedef struct packed {
        logic  valid;
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // One ack per beat
    typedef struct packed {
        logic  ack;
        word_t rdata;
    } mem_rsp_t;

    // Cache controller FSM
    typedef enum logic [1:0] {IDLE, WRITE_BACK, TURNAROUND, REFILL} cache_state_t;

endpackage

`default_nettype wire

// ==== logic/block_cache.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cache_consts.svh"

module block_cache (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire cache_pkg::cpu_req_t cpu_req,
    input  wire logic                flush,
    input  wire cache_pkg::mem_rsp_t mem_rsp,
    output cache_pkg::word_t         rdata,
    output logic                     stall,
    output cache_pkg::mem_req_t      mem_req
);

    // ------------------------------
    // Storage and control state
    // ------------------------------

    // Block data, no reset
    cache_pkg::word_t        blk [`CACHE_BLOCK_WORDS];
    // Tag of the block in storage
    cache_pkg::block_tag_t   blk_tag;
    // Tag of the block being fetched
    cache_pkg::block_tag_t   miss_tag;
    logic                    blk_valid;
    logic                    blk_dirty;
    // Write-back was ordered by a flush, not by a miss
    logic                    flush_wb;
    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t next_state;
    // Beat counter for both burst kinds
    cache_pkg::word_index_t  ptr;

    // Request decode
    cache_pkg::block_tag_t   req_tag;
    cache_pkg::word_index_t  req_index;
    logic                    hit;
    logic                    access;
    logic                    serve;
    logic                    beat;
    logic                    last_beat;
    cache_pkg::word_t        be_mask;

    assign req_tag   = cpu_req.addr[`CACHE_WORD_BITS-1:`CACHE_TAG_LSB];
    assign req_index = cpu_req.addr[`CACHE_TAG_LSB-1 -: `CACHE_INDEX_BITS];
    assign hit       = blk_valid && (req_tag == blk_tag);
    assign access    = cpu_req.read || cpu_req.write;

    // Hits are only served when idle and no flush is pending
    assign serve     = (state == cache_pkg::IDLE) && !flush && hit;

    // Only beats of our own burst count
    assign beat      = mem_rsp.ack && mem_req.valid;
    assign last_beat = beat && (ptr == cache_pkg::word_index_t'(`CACHE_BLOCK_WORDS - 1));

    // Stall covers bursts, the flush cycle and any miss
    assign stall = (state != cache_pkg::IDLE) || flush || (access && !hit);

    // Read data is combinational, valid whenever stall is low
    assign rdata = blk[req_index];

    // Byte enables widened to a bit mask
    always_comb begin
        for (int i = 0; i < `CACHE_WORD_BITS / 8; i++) begin
            be_mask[i*8 +: 8] = {8{cpu_req.be[i]}};
        end
    end

    // ------------------------------
    // FSM
    // ------------------------------

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::IDLE: begin
                if (flush) begin
                    // Nothing to write back on an invalid or clean block
                    if (blk_valid && blk_dirty) begin
                        next_state = cache_pkg::WRITE_BACK;
                    end
                end else if (access && !hit) begin
                    // Dirty victim goes out before the refill
                    if (blk_valid && blk_dirty) begin
                        next_state = cache_pkg::WRITE_BACK;
                    end else begin
                        next_state = cache_pkg::REFILL;
                    end
                end
            end
            cache_pkg::WRITE_BACK: begin
                if (last_beat) begin
                    next_state = flush_wb ? cache_pkg::IDLE : cache_pkg::TURNAROUND;
                end
            end
            // One dead cycle between the two bursts
            cache_pkg::TURNAROUND: begin
                next_state = cache_pkg::REFILL;
            end
            cache_pkg::REFILL: begin
                if (last_beat) begin
                    next_state = cache_pkg::IDLE;
                end
            end
            default: begin
                next_state = cache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= cache_pkg::IDLE;
            ptr       <= '0;
            blk_valid <= 1'b0;
            blk_dirty <= 1'b0;
            flush_wb  <= 1'b0;
        end else begin
            state <= next_state;
            // Cause is sampled on the cycle that leaves IDLE
            if (state == cache_pkg::IDLE) begin
                flush_wb <= flush;
            end
            // Pointer wraps back to zero after the last beat
            if (beat) begin
                ptr <= ptr + 1'b1;
            end
            if (serve && cpu_req.write) begin
                blk_dirty <= 1'b1;
            end
            // Block stays valid and turns clean after write-back
            if ((state == cache_pkg::WRITE_BACK) && last_beat) begin
                blk_dirty <= 1'b0;
            end
            if ((state == cache_pkg::REFILL) && last_beat) begin
                blk_valid <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Data path
    // ------------------------------

    always_ff @(posedge clk) begin
        if (serve && cpu_req.write) begin
            // Merge enabled bytes only
            blk[req_index] <= (blk[req_index] & ~be_mask) | (cpu_req.wdata & be_mask);
        end else if ((state == cache_pkg::REFILL) && beat) begin
            blk[ptr] <= mem_rsp.rdata;
        end
        // Hart holds the missing address, latch it for the whole refill
        if (state == cache_pkg::IDLE) begin
            miss_tag <= req_tag;
        end
        if ((state == cache_pkg::REFILL) && last_beat) begin
            blk_tag <= miss_tag;
        end
    end

    // Memory request straight from the state, address fixed per burst
    always_comb begin
        mem_req.valid = (state == cache_pkg::WRITE_BACK) || (state == cache_pkg::REFILL);
        mem_req.we    = (state == cache_pkg::WRITE_BACK);
        if (state == cache_pkg::WRITE_BACK) begin
            mem_req.addr = {blk_tag, {`CACHE_TAG_LSB{1'b0}}};
        end else begin
            mem_req.addr = {miss_tag, {`CACHE_TAG_LSB{1'b0}}};
        end
        mem_req.wdata = blk[ptr];
    end

    // Hart never reads and writes at once
    assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_req.read && cpu_req.write));

    // Every burst starts at word zero
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req.valid) |-> (ptr == '0));

    // Burst address holds for the whole burst
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.valid && $past(mem_req.valid)) |-> $stable(mem_req.addr));

endmodule

`default_nettype wire

// ==== logic/burst_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module burst_arbiter (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire cache_pkg::mem_req_t req_a,
    input  wire cache_pkg::mem_req_t req_b,
    input  wire cache_pkg::mem_rsp_t mem_rsp,
    output cache_pkg::mem_rsp_t      rsp_a,
    output cache_pkg::mem_rsp_t      rsp_b,
    output cache_pkg::mem_req_t      mem_req
);

    // ------------------------------
    // Grant state
    // ------------------------------

    // A burst owns the port
    logic grant_busy;
    // Owner is side B
    logic grant_b;
    // Side B was served last
    logic last_b;

    logic granted_valid;
    logic bus_free;
    logic any_req;
    logic pick_b;

    assign granted_valid = grant_b ? req_b.valid : req_a.valid;

    // Owner dropping valid ends its burst
    assign bus_free = !grant_busy || !granted_valid;
    assign any_req  = req_a.valid || req_b.valid;

    // On a tie the side not served last wins
    assign pick_b = req_b.valid && (!req_a.valid || !last_b);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_busy <= 1'b0;
            grant_b    <= 1'b0;
            // A wins the first tie
            last_b     <= 1'b1;
        end else if (bus_free) begin
            grant_busy <= any_req;
            if (any_req) begin
                grant_b <= pick_b;
                last_b  <= pick_b;
            end
        end
    end

    // ------------------------------
    // Routing
    // ------------------------------

    always_comb begin
        mem_req       = grant_b ? req_b : req_a;
        mem_req.valid = grant_busy && granted_valid;
    end

    // Read data is shared, ack goes to the owner only
    always_comb begin
        rsp_a     = mem_rsp;
        rsp_b     = mem_rsp;
        rsp_a.ack = mem_rsp.ack && grant_busy && !grant_b;
        rsp_b.ack = mem_rsp.ack && grant_busy && grant_b;
    end

    // Ack only reaches a side that is running a burst
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp_a.ack |-> req_a.valid);
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp_b.ack |-> req_b.valid);

    // No grant switch in the middle of a burst
    // Port address and direction hold while valid stays high
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.valid && $past(mem_req.valid))
            |-> ($stable(mem_req.addr) && $stable(mem_req.we)));

endmodule

`default_nettype wire

// ==== logic/cache_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_subsystem (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire cache_pkg::cpu_req_t cpu_a,
    input  wire cache_pkg::cpu_req_t cpu_b,
    input  wire logic                flush_a,
    input  wire logic                flush_b,
    input  wire cache_pkg::mem_rsp_t mem_rsp,
    output cache_pkg::word_t         rdata_a,
    output cache_pkg::word_t         rdata_b,
    output logic                     stall_a,
    output logic                     stall_b,
    output cache_pkg::mem_req_t      mem_req
);

    // ------------------------------
    // Cache to arbiter links
    // ------------------------------

    cache_pkg::mem_req_t mem_req_a;
    cache_pkg::mem_req_t mem_req_b;
    cache_pkg::mem_rsp_t mem_rsp_a;
    cache_pkg::mem_rsp_t mem_rsp_b;

    // Hart A cache
    block_cache cache_a_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (cpu_a),
        .flush   (flush_a),
        .mem_rsp (mem_rsp_a),
        .rdata   (rdata_a),
        .stall   (stall_a),
        .mem_req (mem_req_a)
    );

    // Hart B cache
    block_cache cache_b_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (cpu_b),
        .flush   (flush_b),
        .mem_rsp (mem_rsp_b),
        .rdata   (rdata_b),
        .stall   (stall_b),
        .mem_req (mem_req_b)
    );

    // Whole-burst round-robin onto the memory port
    burst_arbiter arb_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_a   (mem_req_a),
        .req_b   (mem_req_b),
        .mem_rsp (mem_rsp),
        .rsp_a   (mem_rsp_a),
        .rsp_b   (mem_rsp_b),
        .mem_req (mem_req)
    );

endmodule

`default_nettype wire

// ==== tests/tb_cache_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cache_consts.svh"

module tb_cache_subsystem;

    // Whole run is a few thousand cycles, bursts take at most 16 beats of 4 cycles
    localparam int TIMEOUT_CYCLES = 20000;
    // Word storage for 64 KiB, covers both hart ranges
    localparam int MEM_WORDS = 16384;

    logic                clk;
    logic                rst_n;
    cache_pkg::cpu_req_t cpu_a;
    cache_pkg::cpu_req_t cpu_b;
    logic                flush_a;
    logic                flush_b;
    cache_pkg::mem_rsp_t mem_rsp = '0;
    cache_pkg::word_t    rdata_a;
    cache_pkg::word_t    rdata_b;
    logic                stall_a;
    logic                stall_b;
    cache_pkg::mem_req_t mem_req;

    // Memory model storage and the hart view of memory
    cache_pkg::word_t mem [MEM_WORDS];
    cache_pkg::word_t shadow [MEM_WORDS];

    // Separate LCG streams for the memory model and the stimulus
    cache_pkg::word_t rand_model = 32'hac29_fae4;
    cache_pkg::word_t rand_stim  = 32'hac29_fae4;

    // Memory model burst tracking
    logic                   mem_filled = 1'b0;
    cache_pkg::word_index_t beat_cnt;
    logic                   in_burst;
    logic                   must_idle;
    cache_pkg::word_t       burst_addr;
    logic                   burst_we;
    int                     ack_wait;
    int                     cycle_count;

    cache_subsystem dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_a   (cpu_a),
        .cpu_b   (cpu_b),
        .flush_a (flush_a),
        .flush_b (flush_b),
        .mem_rsp (mem_rsp),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .stall_a (stall_a),
        .stall_b (stall_b),
        .mem_req (mem_req)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic cache_pkg::word_t lcg_next(input cache_pkg::word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte lanes with enable set take the new data
    function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_w,
                                                     input cache_pkg::word_t new_w,
                                                     input cache_pkg::byte_en_t be);
        cache_pkg::word_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_equal(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                               input string what);
        if (got !== exp) begin
            $display("error %0t: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            // Random contents, filled once
            if (!mem_filled) begin
                for (int i = 0; i < MEM_WORDS; i++) begin
                    rand_model = lcg_next(rand_model);
                    mem[14'(i)] = rand_model;
                end
                mem_filled = 1'b1;
            end
            mem_rsp   <= '0;
            beat_cnt  = '0;
            in_burst  = 1'b0;
            must_idle = 1'b0;
            ack_wait  = 0;
        end else if (mem_req.valid && (must_idle || (in_burst &&
                     (mem_req.addr != burst_addr || mem_req.we != burst_we)))) begin
            $display("Memory port carried a second request during a burst at %0t", $time);
            abort_run();
        end else begin
            must_idle = 1'b0;
            if (mem_req.valid && !in_burst) begin
                in_burst   = 1'b1;
                burst_addr = mem_req.addr;
                burst_we   = mem_req.we;
            end
            // Beat taken by the cache at this edge
            if (mem_req.valid && mem_rsp.ack) begin
                if (mem_req.we) begin
                    mem[{mem_req.addr[15:6], beat_cnt}] = mem_req.wdata;
                end
                // Valid has to be low in the cycle after the last beat
                if (beat_cnt == 4'(`CACHE_BLOCK_WORDS - 1)) begin
                    in_burst  = 1'b0;
                    must_idle = 1'b1;
                end
                beat_cnt   = beat_cnt + 4'd1;
                rand_model = lcg_next(rand_model);
                ack_wait   = int'(rand_model[17:16]);
            end
            // Next ack after 0 to 3 idle cycles
            if (in_burst && ack_wait == 0) begin
                mem_rsp.ack   <= 1'b1;
                mem_rsp.rdata <= mem[{mem_req.addr[15:6], beat_cnt}];
            end else begin
                mem_rsp.ack <= 1'b0;
                if (in_burst) begin
                    ack_wait = ack_wait - 1;
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        abort_run();
    end

    // ------------------------------
    // Hart side drivers
    // ------------------------------

    // Holds the request until stall is low, returns the read data of that cycle
    task automatic do_access(input logic hart_b, input cache_pkg::cpu_req_t req,
                             output cache_pkg::word_t data, output int stalls);
        stalls = 0;
        @(posedge clk);
        if (hart_b) begin
            cpu_b <= req;
        end else begin
            cpu_a <= req;
        end
        @(negedge clk);
        while (hart_b ? stall_b : stall_a) begin
            stalls++;
            @(negedge clk);
        end
        data = hart_b ? rdata_b : rdata_a;
        // A write hit commits at this edge
        @(posedge clk);
        if (hart_b) begin
            cpu_b <= '0;
        end else begin
            cpu_a <= '0;
        end
    endtask

    task automatic read_check(input logic hart_b, input cache_pkg::word_t addr,
                              output int stalls);
        cache_pkg::cpu_req_t req;
        cache_pkg::word_t    data;
        req      = '0;
        req.read = 1'b1;
        req.addr = addr;
        do_access(hart_b, req, data, stalls);
        check_equal(data, shadow[addr[15:2]], $sformatf("read data at %h", addr));
    endtask

    task automatic write_word(input logic hart_b, input cache_pkg::word_t addr,
                              input cache_pkg::word_t wdata, input cache_pkg::byte_en_t be);
        cache_pkg::cpu_req_t req;
        cache_pkg::word_t    data;
        int                  stalls;
        req       = '0;
        req.write = 1'b1;
        req.addr  = addr;
        req.wdata = wdata;
        req.be    = be;
        do_access(hart_b, req, data, stalls);
        shadow[addr[15:2]] = merge_bytes(shadow[addr[15:2]], wdata, be);
    endtask

    // One-cycle flush pulse, then wait for the write-back to end
    task automatic flush_hart(input logic hart_b);
        @(posedge clk);
        if (hart_b) begin
            flush_b <= 1'b1;
        end else begin
            flush_a <= 1'b1;
        end
        @(posedge clk);
        flush_a <= 1'b0;
        flush_b <= 1'b0;
        @(negedge clk);
        while (hart_b ? stall_b : stall_a) begin
            @(negedge clk);
        end
    endtask

    task automatic check_block(input cache_pkg::word_t base);
        cache_pkg::word_t a;
        for (int i = 0; i < `CACHE_BLOCK_WORDS; i++) begin
            a = base + cache_pkg::word_t'(i * 4);
            check_equal(mem[a[15:2]], shadow[a[15:2]], $sformatf("memory word %h", a));
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic miss_fill_and_hits();
        int stalls;
        read_check(1'b0, 32'h0000_0100, stalls);
        check_equal(cache_pkg::word_t'(stalls > 0), 32'd1, "stall on read miss");
        for (int i = 1; i < `CACHE_BLOCK_WORDS; i++) begin
            read_check(1'b0, 32'h0000_0100 + cache_pkg::word_t'(i * 4), stalls);
            check_equal(cache_pkg::word_t'(stalls), 32'd0, "stall on read hit");
        end
    endtask

    task automatic partial_write_hit();
        int stalls;
        rand_stim = lcg_next(rand_stim);
        write_word(1'b0, 32'h0000_0104, rand_stim, 4'b0101);
        read_check(1'b0, 32'h0000_0104, stalls);
        check_equal(cache_pkg::word_t'(stalls), 32'd0, "stall after write hit");
        rand_stim = lcg_next(rand_stim);
        write_word(1'b0, 32'h0000_0138, rand_stim, 4'b1000);
        read_check(1'b0, 32'h0000_0138, stalls);
    endtask

    // Block 0x100 is dirty, 0x2100 maps onto the same single block
    task automatic evict_dirty_block();
        int stalls;
        read_check(1'b0, 32'h0000_2100, stalls);
        check_equal(cache_pkg::word_t'(stalls > 0), 32'd1, "stall on conflict miss");
        check_block(32'h0000_0100);
    endtask

    task automatic flush_to_memory();
        int stalls;
        rand_stim = lcg_next(rand_stim);
        write_word(1'b0, 32'h0000_2100, rand_stim, 4'b1111);
        rand_stim = lcg_next(rand_stim);
        write_word(1'b0, 32'h0000_213c, rand_stim, 4'b0110);
        flush_hart(1'b0);
        check_block(32'h0000_2100);
        // Block stays valid, so no burst
        read_check(1'b0, 32'h0000_2108, stalls);
        check_equal(cache_pkg::word_t'(stalls), 32'd0, "stall after flush");
    endtask

    task automatic dual_hart_misses();
        int stalls_a;
        int stalls_b;
        // Dirty A block adds a write-back in front of its refill
        rand_stim = lcg_next(rand_stim);
        write_word(1'b0, 32'h0000_2104, rand_stim, 4'b1111);
        fork
            read_check(1'b0, 32'h0000_3000, stalls_a);
            read_check(1'b1, 32'h0000_9000, stalls_b);
        join
        check_equal(cache_pkg::word_t'(stalls_a > 0), 32'd1, "stall on hart A miss");
        check_equal(cache_pkg::word_t'(stalls_b > 0), 32'd1, "stall on hart B miss");
        check_block(32'h0000_2100);
        read_check(1'b1, 32'h0000_903c, stalls_b);
        check_equal(cache_pkg::word_t'(stalls_b), 32'd0, "stall on hart B hit");
    endtask

    // Three conflicting blocks per hart keep misses and evictions frequent
    task automatic mixed_traffic(input int ops);
        logic       hart_b;
        logic [1:0] blk_sel;
        int         stalls;
        cache_pkg::word_t addr;
        for (int n = 0; n < ops; n++) begin
            rand_stim = lcg_next(rand_stim);
            hart_b    = rand_stim[31];
            blk_sel   = rand_stim[21:20] % 2'd3;
            addr      = {16'h0, hart_b, 5'h0, blk_sel, 2'b00, rand_stim[19:16], 2'b00};
            if (rand_stim[30:28] < 3'd4) begin
                read_check(hart_b, addr, stalls);
            end else if (rand_stim[30:28] < 3'd7) begin
                write_word(hart_b, addr, lcg_next(rand_stim), rand_stim[27:24]);
            end else begin
                flush_hart(hart_b);
            end
        end
        flush_hart(1'b0);
        flush_hart(1'b1);
        for (int b = 0; b < 3; b++) begin
            check_block(cache_pkg::word_t'(b * 256));
            check_block(32'h0000_8000 + cache_pkg::word_t'(b * 256));
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        rst_n   = 1'b0;
        cpu_a   = '0;
        cpu_b   = '0;
        flush_a = 1'b0;
        flush_b = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_equal(cache_pkg::word_t'({stall_a, stall_b, mem_req.valid}), 32'd0,
                    "outputs after reset");
        // Hart view starts equal to the model
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[14'(i)] = mem[14'(i)];
        end
        miss_fill_and_hits();
        partial_write_hit();
        evict_dirty_block();
        flush_to_memory();
        dual_hart_misses();
        mixed_traffic(100);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/cache_pkg.sv
logic/block_cache.sv
logic/burst_arbiter.sv
logic/cache_subsystem.sv
tests/tb_cache_subsystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cache subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timing -f vlog.f --top-module tb_cache_subsystem -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log

# Result comes from the log only
grep -qx "Test completed successfully" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
